// File: all.f
src/mem_bus_pkg.sv
src/apb_pkg.sv
src/tcm_rom.sv
src/tcm_ram.sv
src/apb_requester.sv
src/apb_gpio.sv
src/mem_fabric.sv
src/mcu_mem_subsystem.sv
verif/mcu_mem_props.sv
verif/tb_mcu_mem_subsystem.sv

// File: rom_image.hex
// One 32-bit word per line, word 0 first
A5A50000
A5A50001
A5A50002
A5A50003
A5A50004
A5A50005
A5A50006
A5A50007
A5A50008
A5A50009
A5A5000A
A5A5000B
A5A5000C
A5A5000D
A5A5000E
A5A5000F

// File: run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f all.f \
	--top-module tb_mcu_mem_subsystem \
	-o sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim > sim.log 2>&1
grep -qF "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

// File: src/apb_gpio.sv
`default_nettype none

module apb_gpio import apb_pkg::*; (
	input wire logic		clk,
	input wire logic		reset,

	input wire apb_req_t	apb_req,
	output apb_resp_t		apb_resp,

	input wire logic [31:0]	gpio_in,
	output logic [31:0]		gpio_out
);

	logic access;
	logic sel_out;
	logic sel_in;
	logic illegal;

	////////////////////////////////////////////////////////////
	// Register decode

	always_comb begin
		access	= apb_req.psel && apb_req.penable;
		sel_out	= (apb_req.paddr == GPIO_OUT_OFS);
		sel_in	= (apb_req.paddr == GPIO_IN_OFS);

		// Unknown offset, or a write to the input pins
		illegal	= !(sel_out || sel_in) || (sel_in && apb_req.pwrite);
	end

	// No wait states, every access phase completes
	always_comb begin
		apb_resp.pready		= access;
		apb_resp.pslverr	= access && illegal;
		apb_resp.prdata		= '0;
		if (access && !apb_req.pwrite) begin
			if (sel_out)
				apb_resp.prdata = gpio_out;
			else if (sel_in)
				apb_resp.prdata = gpio_in;
		end
	end

	////////////////////////////////////////////////////////////
	// Output register

	// Only strobed bytes change
	always_ff @(posedge clk) begin
		if (reset) begin
			gpio_out <= '0;
		end else if (access && apb_req.pwrite && sel_out) begin
			for (int i = 0; i < 4; i++) begin
				if (apb_req.pstrb[i])
					gpio_out[8*i +: 8] <= apb_req.pwdata[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

// File: src/apb_pkg.sv
`default_nettype none

package apb_pkg;

	// Offset width inside the APB window
	localparam int APB_AW = 12;

	////////////////////////////////////////////////////////////
	// APB transfer signals

	// Requester side
	typedef struct packed {
		logic				psel;
		logic				penable;
		logic				pwrite;
		logic [APB_AW-1:0]	paddr;
		logic [31:0]		pwdata;
		logic [3:0]			pstrb;
	} apb_req_t;

	// Completer side
	typedef struct packed {
		logic			pready;
		logic			pslverr;
		logic [31:0]	prdata;
	} apb_resp_t;

	////////////////////////////////////////////////////////////
	// GPIO register offsets

	// Output latch, read and write
	localparam logic [APB_AW-1:0] GPIO_OUT_OFS	= 12'h000;
	// Input pins, read only
	localparam logic [APB_AW-1:0] GPIO_IN_OFS	= 12'h004;

endpackage

`default_nettype wire

// File: src/apb_requester.sv
`default_nettype none

module apb_requester import mem_bus_pkg::*, apb_pkg::*; (
	input wire logic		clk,
	input wire logic		reset,

	// From the fabric
	input wire logic		start,
	input wire mem_req_t	req,
	output logic			done,
	output logic			done_err,
	output logic [31:0]		done_data,

	// APB side
	output apb_req_t		apb_req,
	input wire apb_resp_t	apb_resp
);

	typedef enum logic [1:0] {
		st_idle,
		st_setup,
		st_access
	} state_t;

	state_t				state;

	// Transfer fields, held for the whole transfer
	logic [APB_AW-1:0]	addr_q;
	logic				write_q;
	logic [31:0]		wdata_q;
	logic [3:0]			strb_q;

	////////////////////////////////////////////////////////////
	// Phase sequencing

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:	if (start) state <= st_setup;
				st_setup:	state <= st_access;
				// Wait states just keep us here
				st_access:	if (apb_resp.pready) state <= st_idle;
				default:	state <= st_idle;
			endcase
		end
	end

	// Latch offset, direction, data and strobes on start
	always_ff @(posedge clk) begin
		if (start && (state == st_idle)) begin
			addr_q	<= req.addr[APB_AW-1:0];
			write_q	<= |req.wstrb;
			wdata_q	<= req.wdata;
			strb_q	<= req.wstrb;
		end
	end

	////////////////////////////////////////////////////////////
	// Bus outputs

	always_comb begin
		apb_req.psel	= (state != st_idle);
		apb_req.penable	= (state == st_access);
		apb_req.pwrite	= write_q;
		apb_req.paddr	= addr_q;
		apb_req.pwdata	= wdata_q;
		apb_req.pstrb	= strb_q;
	end

	// Completion, the fabric registers these
	always_comb begin
		done		= (state == st_access) && apb_resp.pready;
		done_err	= apb_resp.pslverr;
		done_data	= apb_resp.prdata;
	end

endmodule

`default_nettype wire

// File: src/mcu_mem_subsystem.sv
`default_nettype none

module mcu_mem_subsystem import mem_bus_pkg::*, apb_pkg::*; (
	input wire logic		clk,
	input wire logic		reset,

	// CPU memory bus
	input wire mem_req_t	mem_req,
	output mem_resp_t		mem_resp,

	// GPIO pins
	input wire logic [31:0]	gpio_in,
	output logic [31:0]		gpio_out
);

	////////////////////////////////////////////////////////////
	// Internal APB

	// Single peripheral on the bus, no select decode needed
	apb_req_t	apb_req;
	apb_resp_t	apb_resp;

	////////////////////////////////////////////////////////////
	// Fabric with ROM, RAM and APB requester

	mem_fabric i_mem_fabric (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_resp(mem_resp),
		.apb_req(apb_req),
		.apb_resp(apb_resp)
	);

	////////////////////////////////////////////////////////////
	// GPIO peripheral

	apb_gpio i_apb_gpio (
		.clk(clk),
		.reset(reset),
		.apb_req(apb_req),
		.apb_resp(apb_resp),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out)
	);

endmodule

`default_nettype wire

// File: src/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

	////////////////////////////////////////////////////////////
	// Core memory bus

	// Request as it leaves the CPU, zero wstrb is a read
	typedef struct packed {
		logic			valid;
		logic [31:0]	addr;
		logic [31:0]	wdata;
		logic [3:0]		wstrb;
	} mem_req_t;

	// Response, ready is a single cycle pulse
	typedef struct packed {
		logic			ready;
		logic			fault;
		logic [31:0]	rdata;
	} mem_resp_t;

	////////////////////////////////////////////////////////////
	// Memory map

	localparam logic [31:0] ROM_BASE	= 32'h0800_0000;
	localparam logic [31:0] ROM_SIZE	= 32'd1024;
	localparam logic [31:0] RAM_BASE	= 32'h2000_0000;
	localparam logic [31:0] RAM_SIZE	= 32'd1024;
	localparam logic [31:0] APB_BASE	= 32'h4000_0000;
	localparam logic [31:0] APB_SIZE	= 32'h1000_0000;

	// Sizes in words and word address widths
	localparam int ROM_WORDS	= ROM_SIZE / 4;
	localparam int RAM_WORDS	= RAM_SIZE / 4;
	localparam int ROM_AW		= $clog2(ROM_WORDS);
	localparam int RAM_AW		= $clog2(RAM_WORDS);

	// Boot image, loaded at elaboration
	localparam string ROM_IMAGE	= "rom_image.hex";

endpackage

`default_nettype wire

// File: src/mem_fabric.sv
`default_nettype none

module mem_fabric import mem_bus_pkg::*, apb_pkg::*; (
	input wire logic		clk,
	input wire logic		reset,

	input wire mem_req_t	mem_req,
	output mem_resp_t		mem_resp,

	output apb_req_t		apb_req,
	input wire apb_resp_t	apb_resp
);

	logic			busy;
	logic			accept;
	logic			is_rom, is_ram, is_apb, is_write, dec_fault;
	logic			rom_rd_en, ram_rd_en, apb_start;
	logic [3:0]		ram_wr_en;
	logic			rom_pend, ram_pend;
	logic [31:0]	rom_data, ram_data, apb_data;
	logic			apb_done, apb_err;
	mem_resp_t		resp_d;

	////////////////////////////////////////////////////////////
	// Decode and acceptance

	always_comb begin
		// Offset compare wraps below the base, so one test per range
		is_rom		= (mem_req.addr - ROM_BASE) < ROM_SIZE;
		is_ram		= (mem_req.addr - RAM_BASE) < RAM_SIZE;
		is_apb		= (mem_req.addr - APB_BASE) < APB_SIZE;
		is_write	= |mem_req.wstrb;

		// A held request is never taken twice
		accept		= mem_req.valid && !busy && !mem_resp.ready;

		rom_rd_en	= accept && is_rom && !is_write;
		ram_rd_en	= accept && is_ram && !is_write;
		ram_wr_en	= (accept && is_ram) ? mem_req.wstrb : 4'b0;
		apb_start	= accept && is_apb;

		// Unmapped, or a write to ROM
		dec_fault	= accept && (!(is_rom || is_ram || is_apb) || (is_rom && is_write));
	end

	////////////////////////////////////////////////////////////
	// Targets

	tcm_rom i_tcm_rom (
		.clk(clk),
		.rd_en(rom_rd_en),
		.rd_addr(mem_req.addr[2 +: ROM_AW]),
		.rd_data(rom_data)
	);

	tcm_ram i_tcm_ram (
		.clk(clk),
		.wr_en(ram_wr_en),
		.rd_en(ram_rd_en),
		.addr(mem_req.addr[2 +: RAM_AW]),
		.wr_data(mem_req.wdata),
		.rd_data(ram_data)
	);

	apb_requester i_apb_requester (
		.clk(clk),
		.reset(reset),
		.start(apb_start),
		.req(mem_req),
		.done(apb_done),
		.done_err(apb_err),
		.done_data(apb_data),
		.apb_req(apb_req),
		.apb_resp(apb_resp)
	);

	////////////////////////////////////////////////////////////
	// Response mux

	// Sources are exclusive, one request in flight
	always_comb begin
		resp_d = '0;
		if (dec_fault) begin
			resp_d.ready = 1'b1;
			resp_d.fault = 1'b1;
		end else if (accept && is_ram && is_write) begin
			resp_d.ready = 1'b1;
		end
		if (rom_pend) begin
			resp_d.ready = 1'b1;
			resp_d.rdata = rom_data;
		end
		if (ram_pend) begin
			resp_d.ready = 1'b1;
			resp_d.rdata = ram_data;
		end
		// Slave error becomes a fault with zero data
		if (apb_done) begin
			resp_d.ready = 1'b1;
			resp_d.fault = apb_err;
			resp_d.rdata = apb_err ? '0 : apb_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mem_resp	<= '0;
			busy		<= 1'b0;
			rom_pend	<= 1'b0;
			ram_pend	<= 1'b0;
		end else begin
			mem_resp	<= resp_d;
			// Single cycle answers never set busy
			busy		<= (busy || accept) && !resp_d.ready;
			rom_pend	<= rom_rd_en;
			ram_pend	<= ram_rd_en;
		end
	end

endmodule

`default_nettype wire

// File: src/tcm_ram.sv
`default_nettype none

module tcm_ram import mem_bus_pkg::*; (
	input wire logic				clk,

	// One write enable per byte lane
	input wire logic [3:0]			wr_en,
	input wire logic				rd_en,
	input wire logic [RAM_AW-1:0]	addr,
	input wire logic [31:0]			wr_data,
	output logic [31:0]				rd_data
);

	////////////////////////////////////////////////////////////
	// Byte lane arrays

	// Lane 0 holds bits 7:0, lane 3 holds bits 31:24
	logic [7:0] lanes [4][RAM_WORDS];

	////////////////////////////////////////////////////////////
	// Strobed write, registered read

	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin

			// Untouched lanes keep their old byte
			if (wr_en[i]) begin
				lanes[i][addr] <= wr_data[8*i +: 8];
			end

			// All four lanes come back together
			if (rd_en) begin
				rd_data[8*i +: 8] <= lanes[i][addr];
			end

		end
	end

endmodule

`default_nettype wire

// File: src/tcm_rom.sv
`default_nettype none

module tcm_rom import mem_bus_pkg::*; (
	input wire logic				clk,

	input wire logic				rd_en,
	input wire logic [ROM_AW-1:0]	rd_addr,
	output logic [31:0]				rd_data
);

	////////////////////////////////////////////////////////////
	// Storage

	logic [31:0] rom [ROM_WORDS];

	// Words past the end of the image read as zero
	initial begin
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = '0;
		end
		$readmemh(ROM_IMAGE, rom);
	end

	////////////////////////////////////////////////////////////
	// Registered read

	// Data shows up the cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= rom[rd_addr];
		end
	end

endmodule

`default_nettype wire

// File: verif/mcu_mem_props.sv
`default_nettype none

module mcu_mem_props import mem_bus_pkg::*, apb_pkg::*; (
	input wire logic		clk,
	input wire logic		reset,
	input wire mem_resp_t	mem_resp,
	input wire apb_req_t	apb_req,
	input wire apb_resp_t	apb_resp
);

	// Read by the testbench at the end of the run
	int violations = 0;

	////////////////////////////////////////////////////////////
	// CPU bus

	// Ready never lasts two cycles
	ready_pulse: assert property (@(posedge clk) disable iff (reset)
		mem_resp.ready |=> !mem_resp.ready)
		else begin
			violations++;
			$error("ready held high for more than one cycle");
		end

	fault_with_ready: assert property (@(posedge clk) disable iff (reset)
		mem_resp.fault |-> mem_resp.ready)
		else begin
			violations++;
			$error("fault raised without ready");
		end

	////////////////////////////////////////////////////////////
	// APB

	penable_with_psel: assert property (@(posedge clk) disable iff (reset)
		apb_req.penable |-> apb_req.psel)
		else begin
			violations++;
			$error("penable high while psel is low");
		end

	// Transfer still open, so address and control hold
	apb_stable: assert property (@(posedge clk) disable iff (reset)
		apb_req.psel && !(apb_req.penable && apb_resp.pready) |=>
			apb_req.psel && $stable(apb_req.paddr) && $stable(apb_req.pwrite)
			&& $stable(apb_req.pwdata) && $stable(apb_req.pstrb))
		else begin
			violations++;
			$error("APB address or control changed before pready");
		end

endmodule

bind mcu_mem_subsystem mcu_mem_props i_mcu_mem_props (
	.clk(clk),
	.reset(reset),
	.mem_resp(mem_resp),
	.apb_req(apb_req),
	.apb_resp(apb_resp)
);

`default_nettype wire

// File: verif/tb_mcu_mem_subsystem.sv
`default_nettype none

module tb_mcu_mem_subsystem import mem_bus_pkg::*, apb_pkg::*; ();

	// Expected answer for one request
	typedef struct packed {
		logic [1:0]		lat;
		logic			fault;
		logic [31:0]	rdata;
	} expect_t;

	// Tests take about 1800 cycles
	localparam int MAX_CYCLES	= 6000;
	localparam int READY_LIMIT	= 8;

	logic			clk;
	logic			reset;
	mem_req_t		mem_req;
	mem_resp_t		mem_resp;
	logic [31:0]	gpio_in;
	logic [31:0]	gpio_out;

	// Reference state
	logic [31:0]	shadow_ram [RAM_WORDS];
	logic [31:0]	gpio_shadow;
	expect_t		exp_cur;
	logic			pending;

	integer			seed;
	int				cycles = 0;
	int				errors = 0;
	int				checks = 0;
	int				test_start;
	int				tests = 0;

	mcu_mem_subsystem i_mcu_mem_subsystem (
		.clk(clk),
		.reset(reset),
		.mem_req(mem_req),
		.mem_resp(mem_resp),
		.gpio_in(gpio_in),
		.gpio_out(gpio_out)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, tests did not finish", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
			input logic [31:0] data, input logic [3:0] strb);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (strb[i])
				res[8*i +: 8] = data[8*i +: 8];
		end
		return res;
	endfunction

	function automatic expect_t ref_model(input logic [31:0] addr, input logic [3:0] wstrb);
		expect_t		e;
		logic			write;
		logic [11:0]	ofs;
		e = '0;
		write = |wstrb;
		ofs = addr[11:0];
		if (addr >= ROM_BASE && addr < ROM_BASE + ROM_SIZE) begin
			e.lat = write ? 2'd1 : 2'd2;
			e.fault = write;
			// Image rule, past word 15 the ROM reads zero
			if (!write && addr[9:2] < 8'd16)
				e.rdata = 32'hA5A5_0000 + {24'b0, addr[9:2]};
		end else if (addr >= RAM_BASE && addr < RAM_BASE + RAM_SIZE) begin
			e.lat = write ? 2'd1 : 2'd2;
			if (!write)
				e.rdata = shadow_ram[addr[9:2]];
		end else if (addr >= APB_BASE && addr < APB_BASE + APB_SIZE) begin
			e.lat = 2'd3;
			if (ofs == 12'h000)
				e.rdata = write ? 32'h0 : gpio_shadow;
			else if (ofs == 12'h004 && !write)
				e.rdata = gpio_in;
			else
				e.fault = 1'b1;
		end else begin
			// Unmapped
			e.lat = 2'd1;
			e.fault = 1'b1;
		end
		return e;
	endfunction

	task automatic update_shadow(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, input logic fault);
		if (!fault && (|wstrb)) begin
			if (addr >= RAM_BASE && addr < RAM_BASE + RAM_SIZE)
				shadow_ram[addr[9:2]] = merge_bytes(shadow_ram[addr[9:2]], wdata, wstrb);
			else if (addr >= APB_BASE && addr < APB_BASE + APB_SIZE && addr[11:0] == 12'h000)
				gpio_shadow = merge_bytes(gpio_shadow, wdata, wstrb);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Checking

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		checks++;
		if (got !== want) begin
			$display("FAILED %s: got %h, expected %h", name, got, want);
			errors++;
		end
	endtask

	// Every ready is compared here
	always @(negedge clk) begin
		if (!reset && mem_resp.ready) begin
			if (!pending) begin
				$display("Ready seen with no request outstanding");
				errors++;
			end else begin
				check_value("mem_resp.fault", 32'(mem_resp.fault), 32'(exp_cur.fault));
				check_value("mem_resp.rdata", mem_resp.rdata, exp_cur.rdata);
			end
			pending = 1'b0;
		end
	end

	task automatic report_test(input string name);
		tests++;
		if (errors == test_start)
			$display("Test %0d %s: ok", tests, name);
		else
			$display("Test %0d %s: %0d errors", tests, name, errors - test_start);
		test_start = errors;
	endtask

	////////////////////////////////////////////////////////////
	// Bus driver

	// Hold the request until ready, then drop it
	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb);
		int lat;
		@(posedge clk);
		#1;
		exp_cur = ref_model(addr, wstrb);
		pending = 1'b1;
		mem_req.valid = 1'b1;
		mem_req.addr = addr;
		mem_req.wdata = wdata;
		mem_req.wstrb = wstrb;
		lat = 0;
		do begin
			@(posedge clk);
			#1;
			lat++;
		end while (!mem_resp.ready && lat < READY_LIMIT);
		mem_req = '0;
		if (!mem_resp.ready) begin
			$display("No ready for address %h within %0d cycles", addr, READY_LIMIT);
			errors++;
		end
		check_value("ready latency", 32'(lat), 32'(exp_cur.lat));
		update_shadow(addr, wdata, wstrb, exp_cur.fault);
		check_value("gpio_out", gpio_out, gpio_shadow);
	endtask

	function automatic logic [3:0] random_strobe(input logic [31:0] r);
		// Zero would turn the write into a read
		return (r[3:0] == 4'h0) ? 4'hF : r[3:0];
	endfunction

	////////////////////////////////////////////////////////////
	// Tests

	task automatic test_ram_random();
		logic [31:0] a;
		logic [31:0] written [$];
		// Fill pattern from the whole word address
		for (int i = 0; i < RAM_WORDS; i++) begin
			a = RAM_BASE + 32'(i * 4);
			bus_access(a, {8'h3C, 8'(i), ~8'(i), 8'(i)}, 4'hF);
		end
		for (int i = 0; i < 40; i++) begin
			a = RAM_BASE + ($random(seed) & 32'h0000_03FC);
			written.push_back(a);
			bus_access(a, $random(seed), random_strobe($random(seed)));
		end
		foreach (written[i])
			bus_access(written[i], 32'h0, 4'h0);
	endtask

	task automatic test_gpio();
		gpio_in = $random(seed);
		bus_access(APB_BASE | 32'(GPIO_OUT_OFS), 32'h1122_3344, 4'b0011);
		bus_access(APB_BASE | 32'(GPIO_OUT_OFS), 32'hAABB_CCDD, 4'b1100);
		bus_access(APB_BASE | 32'(GPIO_OUT_OFS), $random(seed), 4'b0100);
		bus_access(APB_BASE | 32'(GPIO_OUT_OFS), 32'h0, 4'h0);
		bus_access(APB_BASE | 32'(GPIO_IN_OFS), 32'h0, 4'h0);
		bus_access(APB_BASE | 32'(GPIO_OUT_OFS), $random(seed), 4'b1001);
		gpio_in = $random(seed);
		bus_access(APB_BASE | 32'(GPIO_IN_OFS), 32'h0, 4'h0);
		bus_access(APB_BASE | 32'(GPIO_OUT_OFS), 32'h0, 4'h0);
	endtask

	task automatic test_faults();
		bus_access(32'h1000_0000, 32'h0, 4'h0);
		bus_access(RAM_BASE + RAM_SIZE, 32'hDEAD_BEEF, 4'hF);
		bus_access(ROM_BASE + 32'h8, 32'hDEAD_BEEF, 4'hF);
		bus_access(APB_BASE | 32'(GPIO_IN_OFS), 32'hDEAD_BEEF, 4'hF);
		bus_access(APB_BASE + 32'h8, 32'h0, 4'h0);
		bus_access(APB_BASE + 32'h10, 32'hDEAD_BEEF, 4'h3);
		// Nothing behind the faults may have moved
		bus_access(ROM_BASE + 32'h8, 32'h0, 4'h0);
		// Word 0 is where the write past the RAM end would wrap to
		bus_access(RAM_BASE, 32'h0, 4'h0);
		bus_access(APB_BASE | 32'(GPIO_OUT_OFS), 32'h0, 4'h0);
	endtask

	task automatic test_random_mix();
		logic [31:0] r;
		logic [31:0] ofs;
		for (int n = 0; n < 300; n++) begin
			r = $random(seed);
			ofs = $random(seed);
			case (r[2:0])
				3'd0:		bus_access(ROM_BASE + (ofs & 32'h3FC), 32'h0, 4'h0);
				3'd1:		bus_access(RAM_BASE + (ofs & 32'h3FC), 32'h0, 4'h0);
				3'd2, 3'd3:	bus_access(RAM_BASE + (ofs & 32'h3FC), $random(seed),
								random_strobe(r[7:4]));
				// Offsets 0, 4, 8 and C, the last two illegal
				3'd4:		bus_access(APB_BASE + {28'h0, ofs[1:0], 2'b00}, 32'h0, 4'h0);
				3'd5:		bus_access(APB_BASE + {28'h0, ofs[1:0], 2'b00}, $random(seed),
								random_strobe(r[7:4]));
				3'd6:		bus_access(32'h6000_0000 | (ofs & 32'h0FFF_FFFC), 32'h0, 4'h0);
				default:	bus_access(ROM_BASE + (ofs & 32'h3FC), $random(seed), 4'hF);
			endcase
			if (n % 50 == 0)
				gpio_in = $random(seed);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		seed = 32'h9744_a03a;
		reset = 1'b1;
		mem_req = '0;
		gpio_in = '0;
		gpio_shadow = '0;
		pending = 1'b0;
		test_start = 0;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < 16; i++)
			bus_access(ROM_BASE + 32'(i * 4), 32'h0, 4'h0);
		report_test("ROM image reads");
		test_ram_random();
		report_test("RAM random writes and reads");
		test_gpio();
		report_test("GPIO strobed writes and readback");
		test_faults();
		report_test("fault responses");
		test_random_mix();
		report_test("random mix");

		// Assertion failures count as errors too
		errors += i_mcu_mem_subsystem.i_mcu_mem_props.violations;
		$display("Done: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
